//--- hw/regif_pkg.sv
//====================================================================
// Widths, address map and bus structs shared by the register subsystem
// Modules pull these in with a wildcard import in their header
//====================================================================
package regif_pkg;

    localparam int ADDR_W = 12;             // Byte address
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;     // One strobe per byte

    // Bank bases, bit 8 picks the bank
    localparam logic [ADDR_W-1:0] CTRL_BASE      = 12'h000;
    localparam logic [ADDR_W-1:0] MBOX_BASE      = 12'h100;
    localparam logic [ADDR_W-1:0] CTRL_ID_OFS    = 12'h010;
    localparam logic [ADDR_W-1:0] MBOX_DATA_OFS  = 12'h000;  // Push/pop window
    localparam logic [ADDR_W-1:0] MBOX_COUNT_OFS = 12'h004;  // Fill level
    localparam logic [DATA_W-1:0] CTRL_ID_VALUE  = 32'h5245_4701;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } rsp_t;

    // Register block request, one strobe per access
    typedef struct packed {
        logic              req;
        logic              is_wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wr_data;
        logic [DATA_W-1:0] wr_biten;
    } regblk_req_t;

    typedef struct packed {
        logic              stall_wr;
        logic              stall_rd;
        logic              rd_ack;
        logic              rd_err;
        logic [DATA_W-1:0] rd_data;
        logic              wr_ack;
        logic              wr_err;
    } regblk_rsp_t;

endpackage

//--- hw/apb_cmd_bridge.sv
//====================================================================
// APB completer, one command per transfer, pready held off until the
// matching response comes back
//====================================================================
`timescale 1ns/10ps

module apb_cmd_bridge
    import regif_pkg::*;
(
    input  logic              aclk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    input  logic [STRB_W-1:0] pstrb,
    output logic              pready,
    output logic              pslverr,
    output logic [DATA_W-1:0] prdata,
    output logic              cmd_valid,
    input  logic              cmd_ready,
    output cmd_t              cmd,
    input  logic              rsp_valid,
    output logic              rsp_ready,
    input  rsp_t              rsp
);

    typedef enum logic {
        ST_ISSUE = 1'b0,    // Looking for an access phase
        ST_WAIT  = 1'b1     // Command taken, response pending
    } state_t;

    state_t state;
    state_t state_next;
    logic   access;         // Access phase on the bus
    logic   done;           // Transfer answered, no re-issue yet

    assign access = psel && penable;

    // Command straight off the APB lines
    assign cmd_valid = (state == ST_ISSUE) && access && !done;
    assign cmd       = '{write: pwrite, addr: paddr, wdata: pwdata,
                         strb: pwrite ? pstrb : '0};   // Reads carry no strobe

    assign rsp_ready = (state == ST_WAIT);
    assign pready    = (state == ST_WAIT) && rsp_valid;   // Same cycle as response
    assign prdata    = rsp.rdata;
    assign pslverr   = pready && rsp.err;

    always_comb begin
        state_next = state;
        case (state)
            ST_ISSUE: if (cmd_valid && cmd_ready) state_next = ST_WAIT;
            ST_WAIT:  if (rsp_valid) state_next = ST_ISSUE;
            default:  state_next = ST_ISSUE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= ST_ISSUE;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            if (pready) begin
                done <= 1'b1;
            end else if (!access) begin
                done <= 1'b0;   // Idle or new setup phase
            end
        end
    end

endmodule

//--- hw/regblk_adapter.sv
//====================================================================
// Command/response to register block adapter with stall retry
// Sits between the APB bridge and the bank merge
//====================================================================
`timescale 1ns/10ps

module regblk_adapter
    import regif_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  cmd_t        cmd,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output rsp_t        rsp,
    output regblk_req_t blk_req,
    input  regblk_rsp_t blk_rsp
);

    typedef enum logic [1:0] {
        CMD_IDLE     = 2'b00,   // Free for a new command
        CMD_WAIT_ACK = 2'b01,   // Request issued, ack due
        CMD_STALLED  = 2'b10    // Request held until stall drops
    } cmd_state_t;

    cmd_state_t  cmd_state;
    cmd_state_t  cmd_state_next;
    regblk_req_t live_req;      // Request built from the live command
    regblk_req_t r_req;         // Captured at the handshake
    logic        live_stall;
    logic        r_stall;
    logic        ack;
    logic        rsp_pend;      // Response waiting on rsp_ready

    // Byte strobes to bit enables
    function automatic logic [DATA_W-1:0] biten_of(input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] biten;
        for (int b = 0; b < STRB_W; b++) begin
            biten[b*8 +: 8] = {8{strb[b]}};
        end
        return biten;
    endfunction

    assign live_req = '{req: cmd_valid, is_wr: cmd.write, addr: cmd.addr,
                        wr_data: cmd.wdata, wr_biten: biten_of(cmd.strb)};

    // Stall for the direction in play
    assign live_stall = cmd.write ? blk_rsp.stall_wr : blk_rsp.stall_rd;
    assign r_stall    = r_req.is_wr ? blk_rsp.stall_wr : blk_rsp.stall_rd;
    assign ack        = blk_rsp.rd_ack || blk_rsp.wr_ack;
    assign cmd_ready  = (cmd_state == CMD_IDLE);

    // ===================================================================
    // Command FSM
    // ===================================================================
    always_comb begin
        cmd_state_next = cmd_state;
        case (cmd_state)
            CMD_IDLE: begin
                if (cmd_valid) begin
                    cmd_state_next = live_stall ? CMD_STALLED : CMD_WAIT_ACK;
                end
            end
            CMD_WAIT_ACK: if (ack) cmd_state_next = CMD_IDLE;
            CMD_STALLED:  if (!r_stall) cmd_state_next = CMD_WAIT_ACK;  // Retry taken
            default:      cmd_state_next = CMD_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            cmd_state <= CMD_IDLE;
        end else begin
            cmd_state <= cmd_state_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_valid && cmd_ready) begin
            r_req <= live_req;
        end
    end

    // Live command when idle, held copy otherwise
    always_comb begin
        blk_req     = (cmd_state == CMD_IDLE) ? live_req : r_req;
        blk_req.req = (cmd_state == CMD_STALLED) || ((cmd_state == CMD_IDLE) && cmd_valid);
    end

    // ===================================================================
    // Response capture
    // ===================================================================
    always_ff @(posedge aclk) begin
        if (reset) begin
            rsp_pend <= 1'b0;
        end else if (!rsp_pend && ack) begin
            rsp_pend <= 1'b1;
        end else if (rsp_pend && rsp_ready) begin
            rsp_pend <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rsp_pend) begin
            if (blk_rsp.rd_ack) begin
                rsp <= '{rdata: blk_rsp.rd_data, err: blk_rsp.rd_err};
            end else if (blk_rsp.wr_ack) begin
                rsp <= '{rdata: '0, err: blk_rsp.wr_err};  // No data on writes
            end
        end
    end

    assign rsp_valid = rsp_pend;

endmodule

//--- hw/ctrl_regs.sv
//====================================================================
// Control bank, four read/write words under bit enables plus an ID
//====================================================================
`timescale 1ns/10ps

module ctrl_regs
    import regif_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  regblk_req_t req,
    output regblk_rsp_t rsp
);

    logic [DATA_W-1:0] regs [4];
    logic [7:0]        ofs;     // Offset inside the bank
    logic [1:0]        idx;     // Word select
    logic              is_reg;
    logic              is_id;
    logic              rd_hit;
    logic              wr_hit;
    logic              ack_rd;
    logic              ack_wr;
    logic              err_rd;
    logic              err_wr;
    logic [DATA_W-1:0] rdata;

    assign ofs    = req.addr[7:0];
    assign idx    = ofs[3:2];
    assign is_reg = (ofs[7:4] == 4'h0) && (ofs[1:0] == 2'b00);  // 0x0 to 0xC
    assign is_id  = (ofs == CTRL_ID_OFS[7:0]);
    assign rd_hit = req.req && !req.is_wr;
    assign wr_hit = req.req && req.is_wr;

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit && is_reg) begin
            regs[idx] <= (regs[idx] & ~req.wr_biten) | (req.wr_data & req.wr_biten);
        end
    end

    // Ack one cycle after each request
    always_ff @(posedge aclk) begin
        if (reset) begin
            ack_rd <= 1'b0;
            ack_wr <= 1'b0;
        end else begin
            ack_rd <= rd_hit;
            ack_wr <= wr_hit;
        end
    end

    always_ff @(posedge aclk) begin
        err_rd <= !(is_reg || is_id);
        err_wr <= !is_reg;              // ID is read only
        if (is_reg) rdata <= regs[idx];
        else if (is_id) rdata <= CTRL_ID_VALUE;
        else rdata <= '0;               // Unmapped reads zero
    end

    // Never stalls
    assign rsp = '{stall_wr: 1'b0, stall_rd: 1'b0, rd_ack: ack_rd, rd_err: err_rd,
                   rd_data: rdata, wr_ack: ack_wr, wr_err: err_wr};

endmodule

//--- hw/mbox_fifo.sv
//====================================================================
// Mailbox bank, FIFO behind a push/pop data window and a count word
//====================================================================
`timescale 1ns/10ps

module mbox_fifo
    import regif_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic        aclk,
    input  logic        reset,
    input  regblk_req_t req,
    output regblk_rsp_t rsp
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;       // Includes the staged word
    logic              pend_vld;    // Pushed word not yet in storage
    logic [DATA_W-1:0] pend_data;
    logic [7:0]        ofs;
    logic              is_data;
    logic              is_count;
    logic              full;
    logic              empty;
    logic              rd_acc;      // Read taken this cycle
    logic              wr_acc;      // Write taken this cycle
    logic              push;
    logic              pop;
    logic              ack_rd;
    logic              ack_wr;
    logic              err_rd;
    logic              err_wr;
    logic [DATA_W-1:0] rdata;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign ofs      = req.addr[7:0];
    assign is_data  = (ofs == MBOX_DATA_OFS[7:0]);
    assign is_count = (ofs == MBOX_COUNT_OFS[7:0]);
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign rd_acc   = req.req && !req.is_wr && !pend_vld;
    assign wr_acc   = req.req && req.is_wr && !full;
    assign push     = wr_acc && is_data;            // Whole word, enables ignored
    assign pop      = rd_acc && is_data && !empty;

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            pend_vld <= 1'b0;
            ack_rd   <= 1'b0;
            ack_wr   <= 1'b0;
        end else begin
            pend_vld <= push;
            ack_rd   <= rd_acc;
            ack_wr   <= wr_acc;
            if (pend_vld) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            if (push) count <= count + 1'b1;
            else if (pop) count <= count - 1'b1;
        end
    end

    // Storage write lands one cycle after the push
    always_ff @(posedge aclk) begin
        if (push) pend_data <= req.wr_data;
        if (pend_vld) mem[wr_ptr] <= pend_data;
        err_rd <= !(is_count || (is_data && !empty));  // Pop while empty fails
        err_wr <= !is_data;                            // Count is read only
        if (pop) rdata <= mem[rd_ptr];
        else if (is_count) rdata <= DATA_W'(count);
        else rdata <= '0;
    end

    assign rsp = '{stall_wr: full, stall_rd: pend_vld, rd_ack: ack_rd, rd_err: err_rd,
                   rd_data: rdata, wr_ack: ack_wr, wr_err: err_wr};

endmodule

//--- hw/regblk_merge.sv
//====================================================================
// Steers each request to one bank by address bit 8 and folds the two
// bank responses back into one
//====================================================================
`timescale 1ns/10ps

module regblk_merge
    import regif_pkg::*;
(
    input  regblk_req_t req,
    output regblk_rsp_t rsp,
    output regblk_req_t ctrl_req,
    output regblk_req_t mbox_req,
    input  regblk_rsp_t ctrl_rsp,
    input  regblk_rsp_t mbox_rsp
);

    logic hit_ctrl;
    logic hit_mbox;

    assign hit_ctrl = (req.addr[8] == CTRL_BASE[8]);
    assign hit_mbox = (req.addr[8] == MBOX_BASE[8]);

    // Same payload to both, strobe to one
    always_comb begin
        ctrl_req     = req;
        mbox_req     = req;
        ctrl_req.req = req.req && hit_ctrl;
        mbox_req.req = req.req && hit_mbox;
    end

    always_comb begin
        // Stalls only from the addressed bank
        rsp.stall_wr = hit_mbox ? mbox_rsp.stall_wr : ctrl_rsp.stall_wr;
        rsp.stall_rd = hit_mbox ? mbox_rsp.stall_rd : ctrl_rsp.stall_rd;
        rsp.rd_ack   = ctrl_rsp.rd_ack || mbox_rsp.rd_ack;
        rsp.wr_ack   = ctrl_rsp.wr_ack || mbox_rsp.wr_ack;
        rsp.rd_err   = (ctrl_rsp.rd_ack && ctrl_rsp.rd_err) ||
                       (mbox_rsp.rd_ack && mbox_rsp.rd_err);
        rsp.wr_err   = (ctrl_rsp.wr_ack && ctrl_rsp.wr_err) ||
                       (mbox_rsp.wr_ack && mbox_rsp.wr_err);
        if (mbox_rsp.rd_ack) begin
            rsp.rd_data = mbox_rsp.rd_data;
        end else if (ctrl_rsp.rd_ack) begin
            rsp.rd_data = ctrl_rsp.rd_data;
        end else begin
            rsp.rd_data = '0;
        end
    end

endmodule

//--- hw/regif_top.sv
//====================================================================
// Register subsystem top, APB in, control bank and mailbox behind it
//====================================================================
`timescale 1ns/10ps

module regif_top
    import regif_pkg::*;
#(
    parameter int MBOX_DEPTH = 4
) (
    input  logic              aclk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    input  logic [STRB_W-1:0] pstrb,
    output logic              pready,
    output logic              pslverr,
    output logic [DATA_W-1:0] prdata
);

    logic        cmd_valid;
    logic        cmd_ready;
    cmd_t        cmd;
    logic        rsp_valid;
    logic        rsp_ready;
    rsp_t        rsp;
    regblk_req_t blk_req;       // Adapter to merge
    regblk_rsp_t blk_rsp;
    regblk_req_t ctrl_req;
    regblk_rsp_t ctrl_rsp;
    regblk_req_t mbox_req;
    regblk_rsp_t mbox_rsp;

    apb_cmd_bridge i_apb_cmd_bridge (
        .aclk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .pready, .pslverr, .prdata,
        .cmd_valid, .cmd_ready, .cmd,
        .rsp_valid, .rsp_ready, .rsp
    );

    regblk_adapter i_regblk_adapter (
        .aclk, .reset,
        .cmd_valid, .cmd_ready, .cmd,
        .rsp_valid, .rsp_ready, .rsp,
        .blk_req, .blk_rsp
    );

    regblk_merge i_regblk_merge (
        .req      (blk_req),
        .rsp      (blk_rsp),
        .ctrl_req (ctrl_req),
        .mbox_req (mbox_req),
        .ctrl_rsp (ctrl_rsp),
        .mbox_rsp (mbox_rsp)
    );

    ctrl_regs i_ctrl_regs (
        .aclk, .reset,
        .req (ctrl_req),
        .rsp (ctrl_rsp)
    );

    mbox_fifo #(
        .DEPTH (MBOX_DEPTH)
    ) i_mbox_fifo (
        .aclk, .reset,
        .req (mbox_req),
        .rsp (mbox_rsp)
    );

endmodule

//--- tb/tb_regif_top.sv
//======================================================================
// APB testbench for the register subsystem, table of accesses replayed
// in order, expected values built from shadow models of both banks
//======================================================================
`timescale 1ns/10ps

module tb_regif_top
    import regif_pkg::*;
();

    localparam int          MBOX_DEPTH = 4;
    localparam int          TIMEOUT    = 100;           // Cycles allowed per pready wait
    localparam int unsigned SEED       = 32'h5c7e6ecc;

    typedef struct packed {
        cmd_t cmd;      // Access to drive
        rsp_t exp;      // Expected answer
    } entry_t;

    logic              aclk;
    logic              reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [STRB_W-1:0] pstrb;
    logic              pready;
    logic              pslverr;
    logic [DATA_W-1:0] prdata;

    entry_t            tests[$];
    logic [DATA_W-1:0] shadow [4];          // Control bank model
    logic [DATA_W-1:0] mbox_model[$];       // Oldest word first
    int                test_errs;           // Mismatches in the running test
    int                pass_cnt;
    int                fail_cnt;

    regif_top #(
        .MBOX_DEPTH (MBOX_DEPTH)
    ) i_regif_top (
        .aclk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .pready, .pslverr, .prdata
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;    // 4 ns period
    end

    // ==================================================================
    // Models and table building
    // ==================================================================
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
                                                      input logic [DATA_W-1:0] new_val,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];  // Only enabled lanes
        end
        return res;
    endfunction

    task automatic queue_entry(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                               input logic [DATA_W-1:0] exp_data, input logic exp_err);
        entry_t e;
        e.cmd = '{write: wr, addr: addr, wdata: data, strb: strb};
        e.exp = '{rdata: exp_data, err: exp_err};
        tests.push_back(e);
    endtask

    task automatic write_ctrl(input int idx, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
        shadow[idx] = merge_bytes(shadow[idx], data, strb);
        queue_entry(1'b1, CTRL_BASE + ADDR_W'(idx * 4), data, strb, '0, 1'b0);
    endtask

    task automatic read_ctrl(input int idx);
        queue_entry(1'b0, CTRL_BASE + ADDR_W'(idx * 4), '0, '0, shadow[idx], 1'b0);
    endtask

    task automatic push_mbox(input logic [DATA_W-1:0] data);
        mbox_model.push_back(data);
        queue_entry(1'b1, MBOX_BASE + MBOX_DATA_OFS, data, 4'hF, '0, 1'b0);
    endtask

    task automatic pop_mbox();
        logic [DATA_W-1:0] word;
        if (mbox_model.size() == 0) begin
            queue_entry(1'b0, MBOX_BASE + MBOX_DATA_OFS, '0, '0, '0, 1'b1);  // Empty pop
        end else begin
            word = mbox_model.pop_front();
            queue_entry(1'b0, MBOX_BASE + MBOX_DATA_OFS, '0, '0, word, 1'b0);
        end
    endtask

    task automatic read_count();
        queue_entry(1'b0, MBOX_BASE + MBOX_COUNT_OFS, '0, '0, DATA_W'(mbox_model.size()), 1'b0);
    endtask

    task automatic build_tests();
        for (int i = 0; i < 4; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 4; i++) read_ctrl(i);                  // Reset values
        for (int i = 0; i < 4; i++) write_ctrl(i, $urandom(), 4'hF);
        for (int i = 0; i < 4; i++) read_ctrl(i);
        write_ctrl(0, $urandom(), 4'b0101);                         // Partial strobes
        write_ctrl(1, $urandom(), 4'b1000);
        write_ctrl(2, $urandom(), 4'b0110);
        write_ctrl(3, $urandom(), 4'b0000);                         // No lanes at all
        for (int i = 0; i < 4; i++) read_ctrl(i);
        // ID word, then holes in both banks
        queue_entry(1'b0, CTRL_BASE + CTRL_ID_OFS, '0, '0, CTRL_ID_VALUE, 1'b0);
        queue_entry(1'b1, CTRL_BASE + CTRL_ID_OFS, $urandom(), 4'hF, '0, 1'b1);
        queue_entry(1'b0, CTRL_BASE + 12'h020, '0, '0, '0, 1'b1);
        queue_entry(1'b1, CTRL_BASE + 12'h024, $urandom(), 4'hF, '0, 1'b1);
        queue_entry(1'b0, MBOX_BASE + 12'h008, '0, '0, '0, 1'b1);
        queue_entry(1'b1, MBOX_BASE + 12'h00C, $urandom(), 4'hF, '0, 1'b1);
        // Mailbox empty cases
        read_count();
        pop_mbox();
        queue_entry(1'b1, MBOX_BASE + MBOX_COUNT_OFS, $urandom(), 4'hF, '0, 1'b1);
        push_mbox($urandom());                                      // Pop right after push
        pop_mbox();
        push_mbox($urandom());
        read_count();
        push_mbox($urandom());
        read_count();
        pop_mbox();
        read_count();
        pop_mbox();
        read_count();
        for (int i = 0; i < MBOX_DEPTH; i++) push_mbox($urandom());  // Fill to the brim
        read_count();
        for (int i = 0; i < MBOX_DEPTH; i++) pop_mbox();
        read_count();
        pop_mbox();
    endtask

    // ==================================================================
    // Bus driver and checks
    // ==================================================================
    task automatic compare_data(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic drive_apb(input entry_t e, output logic [DATA_W-1:0] rdata,
                             output logic err, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge aclk);
        #1;
        psel    = 1'b1;                     // Setup phase
        penable = 1'b0;
        pwrite  = e.cmd.write;
        paddr   = e.cmd.addr;
        pwdata  = e.cmd.wdata;
        pstrb   = e.cmd.strb;
        @(posedge aclk);
        #1;
        penable = 1'b1;                     // Access phase
        while (!seen && cycles < TIMEOUT) begin
            @(negedge aclk);                // Mid-cycle sample
            if (pready) begin
                seen  = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end else begin
                cycles++;
            end
        end
        @(posedge aclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        int                idx;
        logic              stop;
        logic [DATA_W-1:0] rdata;
        logic              err;
        logic              seen;
        void'($urandom(SEED));              // Seeds the generator once
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pstrb    = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        stop     = 1'b0;
        idx      = 0;
        build_tests();
        repeat (5) @(posedge aclk);
        #1;
        reset = 1'b0;
        while (idx < tests.size() && !stop) begin
            test_errs = 0;
            drive_apb(tests[idx], rdata, err, seen);
            if (!seen) begin
                $display("test %0d: pready never came within %0d cycles, run stopped",
                         idx, TIMEOUT);
                fail_cnt++;
                stop = 1'b1;
            end else begin
                compare_data("prdata", tests[idx].exp.rdata, rdata);
                compare_err("pslverr", tests[idx].exp.err, err);
                $display("test %0d %s addr 0x%03h: %s", idx,
                         tests[idx].cmd.write ? "write" : "read ",
                         tests[idx].cmd.addr, (test_errs == 0) ? "ok" : "mismatch");
                if (test_errs == 0) pass_cnt++;
                else fail_cnt++;
            end
            idx++;
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/regif_pkg.sv
hw/apb_cmd_bridge.sv
hw/regblk_adapter.sv
hw/ctrl_regs.sv
hw/mbox_fifo.sv
hw/regblk_merge.sv
hw/regif_top.sv
tb/tb_regif_top.sv

//--- Bender.yml
package:
  name: regif

sources:
  - files:
      - hw/regif_pkg.sv
      - hw/apb_cmd_bridge.sv
      - hw/regblk_adapter.sv
      - hw/ctrl_regs.sv
      - hw/mbox_fifo.sv
      - hw/regblk_merge.sv
      - hw/regif_top.sv
  - target: test
    files:
      - tb/tb_regif_top.sv
